// ==== hdl/fpu_macros.svh ====
// RV32F execute unit constants
// Opcode fields, FCLASS bit positions and multiplier settings
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// funct5 field, instr[31:27]
`define FUNCT5_FMUL     5'b00010
`define FUNCT5_FSGNJ    5'b00100
`define FUNCT5_FMINMAX  5'b00101
`define FUNCT5_FCMP     5'b10100
`define FUNCT5_FCLASS   5'b11100
`define FUNCT5_FMVWX    5'b11110

// FCLASS result bits, RISC-V order
`define FC_NEG_INF      0
`define FC_NEG_NORM     1
`define FC_NEG_SUB      2
`define FC_NEG_ZERO     3
`define FC_POS_ZERO     4
`define FC_POS_SUB      5
`define FC_POS_NORM     6
`define FC_POS_INF      7
`define FC_SNAN         8
`define FC_QNAN         9

`define EXP_BIAS        127
`define MUL_CYCLES      24
`define CANON_NAN       32'h7fc00000

`endif

// ==== hdl/fpuPkg.sv ====
// Types shared by the single-precision execute unit
// Float fields, operand class, operation and request encodings
package fpuPkg;

typedef logic [31:0] float_t;
typedef logic [7:0]  exp_t;
typedef logic [23:0] sig_t;
typedef logic [9:0]  fclass_t;

// Decoded operand, significand carries the hidden bit
typedef struct packed {
        logic sign;
        exp_t exp;
        sig_t sig;
        logic isZero;
        logic isSub;
        logic isInf;
        logic isNan;
        logic isSnan;
} opClass_t;

typedef enum logic [3:0] {
        OP_NONE,
        OP_FSGNJ,
        OP_FSGNJN,
        OP_FSGNJX,
        OP_FMVXW,
        OP_FMVWX,
        OP_FEQ,
        OP_FLT,
        OP_FLE,
        OP_FMIN,
        OP_FMAX,
        OP_FCLASS,
        OP_FMUL
} fpOp_t;

// One request as issued by the core
typedef struct packed {
        logic [31:0] instr;
        float_t      rs1;
        float_t      rs2;
        logic [2:0]  rm;
} fpuReq_t;

typedef enum logic [1:0] {IDLE, RUN, DONE} ctlState_t;

endpackage

// ==== hdl/fpClassify.sv ====
// Operand classifier
// Splits a float into its fields, restores the hidden bit and
// derives the class flags and the one-hot FCLASS mask
`include "fpu_macros.svh"

module fpClassify
        import fpuPkg::*;
(
        input  float_t   value_i,
        output opClass_t class_o,
        output fclass_t  fclass_o
);

logic        sign;
exp_t        expField;
logic [22:0] frac;
logic        expZero;
logic        expMax;
logic        fracZero;
logic        isNorm;
logic        isInf;
logic        isNan;
logic        isSnan;

assign sign     = value_i[31];
assign expField = value_i[30:23];
assign frac     = value_i[22:0];
assign expZero  = ~|expField;
assign expMax   = &expField;
assign fracZero = ~|frac;
assign isNorm   = ~expZero & ~expMax;
assign isInf    = expMax & fracZero;
assign isNan    = expMax & ~fracZero;
// Quiet bit clear means signalling
assign isSnan   = isNan & ~frac[22];

assign class_o.sign   = sign;
assign class_o.exp    = expField;
assign class_o.sig    = {~expZero, frac};
assign class_o.isZero = expZero & fracZero;
assign class_o.isSub  = expZero & ~fracZero;
assign class_o.isInf  = isInf;
assign class_o.isNan  = isNan;
assign class_o.isSnan = isSnan;

always_comb begin
        fclass_o[`FC_NEG_INF]  = sign & isInf;
        fclass_o[`FC_NEG_NORM] = sign & isNorm;
        fclass_o[`FC_NEG_SUB]  = sign & expZero & ~fracZero;
        fclass_o[`FC_NEG_ZERO] = sign & expZero & fracZero;
        fclass_o[`FC_POS_ZERO] = ~sign & expZero & fracZero;
        fclass_o[`FC_POS_SUB]  = ~sign & expZero & ~fracZero;
        fclass_o[`FC_POS_NORM] = ~sign & isNorm;
        fclass_o[`FC_POS_INF]  = ~sign & isInf;
        fclass_o[`FC_SNAN]     = isSnan;
        fclass_o[`FC_QNAN]     = isNan & ~isSnan;
end

endmodule

// ==== hdl/fpCompare.sv ====
// Float comparator
// Gives FLT, FLE and FEQ for two classified operands, any NaN
// makes every flag false and the two zeros compare equal
module fpCompare
        import fpuPkg::*;
(
        input  opClass_t   a_i,
        input  opClass_t   b_i,
        output logic [2:0] flags_o
);

logic        anyNan;
logic        bothZero;
logic [31:0] magA;
logic [31:0] magB;
logic        magLt;
logic        magEq;
logic        lt;
logic        eq;

assign anyNan   = a_i.isNan | b_i.isNan;
assign bothZero = a_i.isZero & b_i.isZero;

// Exponent above significand orders magnitudes, subnormals too
assign magA  = {a_i.exp, a_i.sig};
assign magB  = {b_i.exp, b_i.sig};
assign magLt = magA < magB;
assign magEq = magA == magB;

always_comb begin
        if (anyNan) begin
                lt = 1'b0;
                eq = 1'b0;
        end else if (bothZero) begin
                lt = 1'b0;
                eq = 1'b1;
        end else if (a_i.sign != b_i.sign) begin
                lt = a_i.sign;
                eq = 1'b0;
        end else begin
                // Both negative flips the magnitude order
                lt = a_i.sign ? (~magLt & ~magEq) : magLt;
                eq = magEq;
        end
end

assign flags_o = {lt, lt | eq, eq};

always_comb begin
        assert (!(flags_o[2] && flags_o[0]))
                else $error("fpCompare: FLT and FEQ both set");
end

endmodule

// ==== hdl/fpMultiply.sv ====
// Iterative single-precision multiplier
// Specials are decided at start, normal operands run a 24 step
// shift-add loop, then one cycle normalizes and rounds to nearest even
`include "fpu_macros.svh"

module fpMultiply
        import fpuPkg::*;
(
        input  logic     clk_i,
        input  logic     rstN_i,
        input  logic     start_i,
        input  opClass_t a_i,
        input  opClass_t b_i,
        output logic     busy_o,
        output logic     done_o,
        output float_t   product_o
);

logic              accept;
logic [4:0]        stepCnt;
logic              lastStep;
sig_t              mcand;
logic [47:0]       prodReg;
logic              prodSign;
logic signed [9:0] expSum;
logic              special;
float_t            specialVal;
logic              zeroA;
logic              zeroB;
logic              nanCase;
logic              infCase;
logic              resSign;
float_t            specialNext;
logic [24:0]       partial;
logic [47:0]       normProd;
logic              roundUp;
logic [23:0]       mantRnd;
logic signed [9:0] expRes;
float_t            roundVal;

assign accept   = start_i & ~busy_o;
assign lastStep = stepCnt == 5'(`MUL_CYCLES);

// Subnormals count as zero
assign zeroA   = a_i.isZero | a_i.isSub;
assign zeroB   = b_i.isZero | b_i.isSub;
assign nanCase = a_i.isNan | b_i.isNan | (zeroA & b_i.isInf) | (a_i.isInf & zeroB);
assign infCase = a_i.isInf | b_i.isInf;
assign resSign = a_i.sign ^ b_i.sign;

always_comb begin
        if (nanCase)
                specialNext = `CANON_NAN;
        else if (infCase)
                specialNext = {resSign, 8'hff, 23'b0};
        else
                specialNext = {resSign, 31'b0};
end

// Add multiplicand into the upper half when the low bit is set
assign partial = {1'b0, prodReg[47:24]} + (prodReg[0] ? {1'b0, mcand} : 25'd0);

// Product lies in [1,4), bring the leading one to bit 47
assign normProd = prodReg[47] ? prodReg : {prodReg[46:0], 1'b0};
assign roundUp  = normProd[23] & ((|normProd[22:0]) | normProd[24]);
assign mantRnd  = {1'b0, normProd[46:24]} + 24'(roundUp);
assign expRes   = expSum - signed'(10'(`EXP_BIAS)) + signed'({9'b0, prodReg[47]})
                + signed'({9'b0, mantRnd[23]});

always_comb begin
        if (expRes >= 10'sd255)
                roundVal = {prodSign, 8'hff, 23'b0};
        else if (expRes <= 10'sd0)
                roundVal = {prodSign, 31'b0};
        else
                roundVal = {prodSign, expRes[7:0], mantRnd[22:0]};
end

always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
                busy_o  <= 1'b0;
                done_o  <= 1'b0;
                stepCnt <= '0;
        end else begin
                done_o <= 1'b0;
                if (accept) begin
                        busy_o  <= 1'b1;
                        stepCnt <= '0;
                end else if (busy_o) begin
                        if (lastStep) begin
                                busy_o <= 1'b0;
                                done_o <= 1'b1;
                        end else begin
                                stepCnt <= stepCnt + 5'd1;
                        end
                end
        end
end

always_ff @(posedge clk_i) begin
        if (accept) begin
                mcand      <= a_i.sig;
                prodReg    <= {24'b0, b_i.sig};
                prodSign   <= resSign;
                expSum     <= signed'({2'b0, a_i.exp} + {2'b0, b_i.exp});
                special    <= nanCase | infCase | zeroA | zeroB;
                specialVal <= specialNext;
        end else if (busy_o && !lastStep) begin
                prodReg <= {partial, prodReg[23:1]};
        end
        if (busy_o && lastStep)
                product_o <= special ? specialVal : roundVal;
end

// Busy can only drop together with done
assert property (@(posedge clk_i) disable iff (!rstN_i)
        (accept || (busy_o && !done_o)) |=> (busy_o || done_o));

assert property (@(posedge clk_i) disable iff (!rstN_i) done_o |=> !done_o);

endmodule

// ==== hdl/fpu.sv ====
// RV32F execute core
// Decodes the instruction word, runs the classifiers, comparator and
// multiplier, and selects one 32-bit result
`include "fpu_macros.svh"

module fpu
        import fpuPkg::*;
(
        input  logic    clk_i,
        input  logic    rstN_i,
        input  logic    start_i,
        input  fpuReq_t req_i,
        output logic    busy_o,
        output logic    done_o,
        output float_t  result_o
);

fpOp_t      op;
logic [4:0] funct5;
logic [2:0] funct3;
logic       isOpFp;
opClass_t   clsA;
opClass_t   clsB;
fclass_t    fclassA;
logic [2:0] cmpFlags;
logic       aLtB;
logic       mulDone;
float_t     mulProduct;

assign funct5 = req_i.instr[31:27];
assign funct3 = req_i.instr[14:12];
// OP-FP major opcode, single precision fmt
assign isOpFp = (req_i.instr[6:0] == 7'b1010011) && (req_i.instr[26:25] == 2'b00);

always_comb begin
        op = OP_NONE;
        if (isOpFp) begin
                case (funct5)
                        `FUNCT5_FMUL:    op = OP_FMUL;
                        `FUNCT5_FSGNJ: begin
                                if (funct3 == 3'b000)      op = OP_FSGNJ;
                                else if (funct3 == 3'b001) op = OP_FSGNJN;
                                else if (funct3 == 3'b010) op = OP_FSGNJX;
                        end
                        `FUNCT5_FMINMAX: begin
                                if (funct3 == 3'b000)      op = OP_FMIN;
                                else if (funct3 == 3'b001) op = OP_FMAX;
                        end
                        `FUNCT5_FCMP: begin
                                if (funct3 == 3'b010)      op = OP_FEQ;
                                else if (funct3 == 3'b001) op = OP_FLT;
                                else if (funct3 == 3'b000) op = OP_FLE;
                        end
                        `FUNCT5_FCLASS: begin
                                if (funct3 == 3'b000)      op = OP_FMVXW;
                                else if (funct3 == 3'b001) op = OP_FCLASS;
                        end
                        `FUNCT5_FMVWX: if (funct3 == 3'b000) op = OP_FMVWX;
                        default: op = OP_NONE;
                endcase
        end
end

fpClassify classA (.value_i(req_i.rs1), .class_o(clsA), .fclass_o(fclassA));
fpClassify classB (.value_i(req_i.rs2), .class_o(clsB), .fclass_o());

fpCompare compare (.a_i(clsA), .b_i(clsB), .flags_o(cmpFlags));

fpMultiply multiply (
        .clk_i    (clk_i),
        .rstN_i   (rstN_i),
        .start_i  (start_i && (op == OP_FMUL)),
        .a_i      (clsA),
        .b_i      (clsB),
        .busy_o   (busy_o),
        .done_o   (mulDone),
        .product_o(mulProduct)
);

// Min/max ordering, -0 sits below +0
assign aLtB = (clsA.isZero && clsB.isZero) ? (clsA.sign & ~clsB.sign) : cmpFlags[2];

always_comb begin
        case (op)
                OP_FSGNJ:  result_o = {req_i.rs2[31], req_i.rs1[30:0]};
                OP_FSGNJN: result_o = {~req_i.rs2[31], req_i.rs1[30:0]};
                OP_FSGNJX: result_o = {req_i.rs1[31] ^ req_i.rs2[31], req_i.rs1[30:0]};
                OP_FMVXW,
                OP_FMVWX:  result_o = req_i.rs1;
                OP_FEQ:    result_o = {31'b0, cmpFlags[0]};
                OP_FLE:    result_o = {31'b0, cmpFlags[1]};
                OP_FLT:    result_o = {31'b0, cmpFlags[2]};
                OP_FMIN,
                OP_FMAX: begin
                        if (clsA.isNan && clsB.isNan)
                                result_o = `CANON_NAN;
                        else if (clsA.isNan)
                                result_o = req_i.rs2;
                        else if (clsB.isNan)
                                result_o = req_i.rs1;
                        else if (aLtB ^ (op == OP_FMAX))
                                result_o = req_i.rs1;
                        else
                                result_o = req_i.rs2;
                end
                OP_FCLASS: result_o = {22'b0, fclassA};
                OP_FMUL:   result_o = mulProduct;
                default:   result_o = 32'b0;
        endcase
end

// Everything except FMUL completes in the start cycle
assign done_o = (op == OP_FMUL) ? mulDone : start_i;

endmodule

// ==== hdl/fpuTop.sv ====
// Request front end of the execute unit
// Four-phase req/ack controller that latches the request, starts
// the core and holds the result while ack is high
module fpuTop
        import fpuPkg::*;
(
        input  logic    clk_i,
        input  logic    rstN_i,
        input  logic    req_i,
        input  fpuReq_t fpuReq_i,
        output logic    ack_o,
        output float_t  result_o
);

ctlState_t state;
fpuReq_t   reqReg;
logic      startReg;
logic      coreBusy;
logic      coreDone;
float_t    coreResult;

always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
                state    <= IDLE;
                startReg <= 1'b0;
        end else begin
                startReg <= 1'b0;
                case (state)
                        IDLE: if (req_i) begin
                                state    <= RUN;
                                startReg <= 1'b1;
                        end
                        RUN:  if (coreDone) state <= DONE;
                        // Stays here until the requester lets go
                        DONE: if (!req_i) state <= IDLE;
                        default: state <= IDLE;
                endcase
        end
end

always_ff @(posedge clk_i) begin
        if (state == IDLE && req_i)
                reqReg <= fpuReq_i;
        if (state == RUN && coreDone)
                result_o <= coreResult;
end

assign ack_o = (state == DONE);

fpu core (
        .clk_i   (clk_i),
        .rstN_i  (rstN_i),
        .start_i (startReg),
        .req_i   (reqReg),
        .busy_o  (coreBusy),
        .done_o  (coreDone),
        .result_o(coreResult)
);

assert property (@(posedge clk_i) disable iff (!rstN_i) $rose(ack_o) |-> $past(req_i));

// Core only works on a request that is in flight
assert property (@(posedge clk_i) disable iff (!rstN_i) coreBusy |-> state == RUN);

endmodule

// ==== test/fpuTbTasks.svh ====
// FPU testbench helpers
// Four-phase request driver, typed result checks and
// RV32F OP-FP instruction encoders

// OP-FP single precision, rs1 = x1, rs2 = x2, rd = x3
function automatic logic [31:0] encodeOpFp(input logic [4:0] funct5, input logic [2:0] funct3);
        logic [4:0] rs2Field;
        // Single-operand forms carry zero in the rs2 field
        rs2Field = (funct5 == `FUNCT5_FCLASS || funct5 == `FUNCT5_FMVWX) ? 5'd0 : 5'd2;
        return {funct5, 2'b00, rs2Field, 5'd1, funct3, 5'd3, 7'b1010011};
endfunction

function automatic fpuReq_t makeReq(input logic [4:0] funct5, input logic [2:0] funct3,
                                    input float_t a, input float_t b);
        fpuReq_t r;
        r.instr = encodeOpFp(funct5, funct3);
        r.rs1   = a;
        r.rs2   = b;
        r.rm    = 3'b000;
        return r;
endfunction

task automatic checkFloat(input string name, input float_t expVal, input float_t actVal);
        if (actVal !== expVal) begin
                $display("Error at %0d ns: %s expected %h, got %h", $time, name, expVal, actVal);
                failCount++;
        end else begin
                passCount++;
        end
endtask

task automatic checkClass(input string name, input fclass_t expVal, input fclass_t actVal);
        if (actVal !== expVal) begin
                $display("Error at %0d ns: %s expected %b, got %b", $time, name, expVal, actVal);
                failCount++;
        end else begin
                passCount++;
        end
endtask

task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
                $display("Error at %0d ns: %s expected %b, got %b", $time, name, expVal, actVal);
                failCount++;
        end else begin
                passCount++;
        end
endtask

task automatic checkCycles(input string name, input int expVal, input int actVal);
        if (actVal != expVal) begin
                $display("Error at %0d ns: %s expected %0d, got %0d", $time, name, expVal, actVal);
                failCount++;
        end else begin
                passCount++;
        end
endtask

// Full req/ack cycle, entered and left 5 ns after a rising edge
// cycles counts the edges from raising req_i to seeing ack_o
task automatic sendOp(input fpuReq_t request, input int holdCycles,
                      output float_t resultVal, output int cycles);
        int waitCnt;
        int i;
        resultVal = '0;
        cycles    = 0;
        if (stalled)
                return;
        fpuReq  = request;
        req     = 1'b1;
        waitCnt = 0;
        while (!ack && waitCnt < 100) begin
                @(posedge clk);
                #5;
                waitCnt++;
        end
        if (!ack) begin
                $display("Handshake stalled: ack_o did not rise within 100 cycles of req_i");
                failCount++;
                stalled = 1'b1;
                req     = 1'b0;
                return;
        end
        cycles    = waitCnt;
        resultVal = resultOut;
        // Requester lingers, ack and result must stay put
        for (i = 0; i < holdCycles; i++) begin
                @(posedge clk);
                #5;
                if (!ack) begin
                        $display("Handshake broken: ack_o dropped while req_i was still high");
                        failCount++;
                end
                checkFloat("result_o while held", resultVal, resultOut);
        end
        req     = 1'b0;
        waitCnt = 0;
        while (ack && waitCnt < 100) begin
                @(posedge clk);
                #5;
                waitCnt++;
        end
        if (ack) begin
                $display("Handshake stalled: ack_o stayed high after req_i dropped");
                failCount++;
                stalled = 1'b1;
        end
endtask

// ==== test/fpuTb.sv ====
// Testbench for the RV32F execute unit
// Directed tests over the four-phase request interface covering sign
// injection, moves, compares, min/max, FCLASS, FMUL and handshake timing
`include "fpu_macros.svh"

module fpuTb
        import fpuPkg::*;
();

timeunit 1ns;
timeprecision 100ps;

logic    clk;
logic    rstN;
logic    req;
fpuReq_t fpuReq;
logic    ack;
float_t  resultOut;
int      passCount;
int      failCount;
logic    stalled;

`include "fpuTbTasks.svh"

fpuTop uut (
        .clk_i   (clk),
        .rstN_i  (rstN),
        .req_i   (req),
        .fpuReq_i(fpuReq),
        .ack_o   (ack),
        .result_o(resultOut)
);

always #50 clk = ~clk;

task automatic reportTest(input string name, input int startFails);
        $display("Test %s finished with %0d errors", name, failCount - startFails);
endtask

task automatic signAndMoves();
        int     startFails;
        int     i;
        int     cycles;
        float_t a;
        float_t b;
        float_t res;
        startFails = failCount;
        for (i = 0; i < 6; i++) begin
                a = $urandom();
                b = $urandom();
                sendOp(makeReq(`FUNCT5_FSGNJ, 3'b000, a, b), 0, res, cycles);
                checkFloat("FSGNJ result_o", {b[31], a[30:0]}, res);
                sendOp(makeReq(`FUNCT5_FSGNJ, 3'b001, a, b), 0, res, cycles);
                checkFloat("FSGNJN result_o", {~b[31], a[30:0]}, res);
                sendOp(makeReq(`FUNCT5_FSGNJ, 3'b010, a, b), 0, res, cycles);
                checkFloat("FSGNJX result_o", {a[31] ^ b[31], a[30:0]}, res);
                sendOp(makeReq(`FUNCT5_FCLASS, 3'b000, a, 32'h0), 0, res, cycles);
                checkFloat("FMV.X.W result_o", a, res);
                sendOp(makeReq(`FUNCT5_FMVWX, 3'b000, a, 32'h0), 0, res, cycles);
                checkFloat("FMV.W.X result_o", a, res);
        end
        reportTest("sign injection and moves", startFails);
endtask

task automatic compareCase(input float_t a, input float_t b,
                           input logic lt, input logic le, input logic eq);
        float_t res;
        int     cycles;
        sendOp(makeReq(`FUNCT5_FCMP, 3'b001, a, b), 0, res, cycles);
        checkFlag("FLT result_o", lt, res[0]);
        sendOp(makeReq(`FUNCT5_FCMP, 3'b000, a, b), 0, res, cycles);
        checkFlag("FLE result_o", le, res[0]);
        sendOp(makeReq(`FUNCT5_FCMP, 3'b010, a, b), 0, res, cycles);
        checkFlag("FEQ result_o", eq, res[0]);
endtask

task automatic compareOps();
        int startFails;
        startFails = failCount;
        compareCase(32'h3f800000, 32'h40000000, 1'b1, 1'b1, 1'b0);
        compareCase(32'h40000000, 32'h3f800000, 1'b0, 1'b0, 1'b0);
        // -2 against -1
        compareCase(32'hc0000000, 32'hbf800000, 1'b1, 1'b1, 1'b0);
        compareCase(32'hbf800000, 32'h3f800000, 1'b1, 1'b1, 1'b0);
        compareCase(32'h3fc00000, 32'h3fc00000, 1'b0, 1'b1, 1'b1);
        // Signed zeros are equal
        compareCase(32'h00000000, 32'h80000000, 1'b0, 1'b1, 1'b1);
        compareCase(32'h80000000, 32'h00000000, 1'b0, 1'b1, 1'b1);
        compareCase(32'h7fc00000, 32'h3f800000, 1'b0, 1'b0, 1'b0);
        compareCase(32'h3f800000, 32'h7f800001, 1'b0, 1'b0, 1'b0);
        compareCase(32'h7fc00000, 32'h7fc00000, 1'b0, 1'b0, 1'b0);
        reportTest("compares", startFails);
endtask

task automatic minMaxCase(input float_t a, input float_t b,
                          input float_t expMin, input float_t expMax);
        float_t res;
        int     cycles;
        sendOp(makeReq(`FUNCT5_FMINMAX, 3'b000, a, b), 0, res, cycles);
        checkFloat("FMIN result_o", expMin, res);
        sendOp(makeReq(`FUNCT5_FMINMAX, 3'b001, a, b), 0, res, cycles);
        checkFloat("FMAX result_o", expMax, res);
endtask

task automatic minMax();
        int startFails;
        startFails = failCount;
        minMaxCase(32'h3f800000, 32'h40000000, 32'h3f800000, 32'h40000000);
        minMaxCase(32'hc0400000, 32'h40000000, 32'hc0400000, 32'h40000000);
        minMaxCase(32'h80000000, 32'h00000000, 32'h80000000, 32'h00000000);
        minMaxCase(32'h00000000, 32'h80000000, 32'h80000000, 32'h00000000);
        // Single NaN yields the other operand
        minMaxCase(32'h7fc00000, 32'h40000000, 32'h40000000, 32'h40000000);
        minMaxCase(32'hbf800000, 32'h7f800001, 32'hbf800000, 32'hbf800000);
        minMaxCase(32'hffc12345, 32'h7f800005, `CANON_NAN, `CANON_NAN);
        reportTest("min and max", startFails);
endtask

task automatic classMasks();
        int     startFails;
        int     i;
        int     cycles;
        float_t res;
        float_t samples [10];
        startFails = failCount;
        // Indexed by FCLASS bit position
        samples = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000, 32'h00000000,
                    32'h00400000, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000};
        for (i = 0; i < 10; i++) begin
                sendOp(makeReq(`FUNCT5_FCLASS, 3'b001, samples[i], 32'h0), 0, res, cycles);
                checkClass("FCLASS result_o", 10'd1 << i, res[9:0]);
                checkFloat("FCLASS upper bits", 32'h0, {res[31:10], 10'b0});
        end
        reportTest("FCLASS", startFails);
endtask

task automatic mulCase(input float_t a, input float_t b, input float_t expVal);
        float_t res;
        int     cycles;
        sendOp(makeReq(`FUNCT5_FMUL, 3'b000, a, b), 0, res, cycles);
        checkFloat("FMUL result_o", expVal, res);
endtask

task automatic multiplyOps();
        int startFails;
        startFails = failCount;
        mulCase(32'h40400000, 32'h40a00000, 32'h41700000);
        mulCase(32'h40000000, 32'h3e800000, 32'h3f000000);
        mulCase(32'hc0800000, 32'h40c00000, 32'hc1c00000);
        mulCase(32'h40e00000, 32'h40e00000, 32'h42440000);
        // (1+2^-23)*1.5 is a tie with an odd lsb and rounds up
        mulCase(32'h3f800001, 32'h3fc00000, 32'h3fc00002);
        // (1+3*2^-23)*1.5 is a tie with an even lsb and stays down
        mulCase(32'h3f800003, 32'h3fc00000, 32'h3fc00004);
        // 2^100 squared overflows
        mulCase(32'h71800000, 32'h71800000, 32'h7f800000);
        mulCase(32'hf1800000, 32'h71800000, 32'hff800000);
        // 2^-100 times -2^-100 flushes to -0
        mulCase(32'h0d800000, 32'h8d800000, 32'h80000000);
        mulCase(32'h00000000, 32'h7f800000, `CANON_NAN);
        mulCase(32'h7fc00000, 32'h3f800000, `CANON_NAN);
        reportTest("FMUL", startFails);
endtask

task automatic handshakeTiming();
        int      startFails;
        int      i;
        int      cycles;
        float_t  res;
        fpuReq_t reqs [4];
        float_t  expVals [4];
        startFails = failCount;
        checkFlag("ack_o after reset", 1'b0, ack);
        sendOp(makeReq(`FUNCT5_FSGNJ, 3'b001, 32'h3f800000, 32'h3f800000), 0, res, cycles);
        checkCycles("ack_o latency", 2, cycles);
        // Sample, start, MUL_CYCLES+1 busy cycles, then ack
        sendOp(makeReq(`FUNCT5_FMUL, 3'b000, 32'h40400000, 32'h40a00000), 0, res, cycles);
        checkCycles("FMUL ack_o latency", `MUL_CYCLES + 4, cycles);
        sendOp(makeReq(`FUNCT5_FSGNJ, 3'b000, 32'h40400000, 32'h80000000), 4, res, cycles);
        checkFloat("held FSGNJ result_o", 32'hc0400000, res);
        reqs[0]    = makeReq(`FUNCT5_FMUL, 3'b000, 32'h40400000, 32'h40a00000);
        expVals[0] = 32'h41700000;
        reqs[1]    = makeReq(`FUNCT5_FSGNJ, 3'b010, 32'hc0000000, 32'hbf800000);
        expVals[1] = 32'h40000000;
        reqs[2]    = makeReq(`FUNCT5_FMUL, 3'b000, 32'hc0800000, 32'h40c00000);
        expVals[2] = 32'hc1c00000;
        reqs[3]    = makeReq(`FUNCT5_FCMP, 3'b010, 32'h3f800000, 32'h3f800000);
        expVals[3] = 32'h00000001;
        for (i = 0; i < 4; i++) begin
                sendOp(reqs[i], 0, res, cycles);
                checkFloat("back-to-back result_o", expVals[i], res);
        end
        reportTest("handshake timing", startFails);
endtask

initial begin
        void'($urandom(32'h3f61));
        clk       = 1'b0;
        rstN      = 1'b0;
        req       = 1'b0;
        fpuReq    = '0;
        passCount = 0;
        failCount = 0;
        stalled   = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rstN = 1'b1;
        handshakeTiming();
        signAndMoves();
        compareOps();
        minMax();
        classMasks();
        multiplyOps();
        $display("Checks passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
                $display("NO ERRORS");
        else
                $display("ERRORS FOUND");
        $finish;
end

endmodule

// ==== filelist.f ====
+incdir+hdl
+incdir+test
hdl/fpuPkg.sv
hdl/fpClassify.sv
hdl/fpCompare.sv
hdl/fpMultiply.sv
hdl/fpu.sv
hdl/fpuTop.sv
test/fpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the FPU testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
        -f filelist.f --top-module fpuTb -o fpuTbSim \
        && ./obj_dir/fpuTbSim > sim.log 2>&1 \
        || { echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "NO ERRORS" sim.log && echo "Simulation passed" \
        || { echo "Simulation failed"; exit 1; }
